//--- Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP ?= rv32iCoreBench
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/programInput.txt
# M addr data | W mask mgmtAddr data | R mask mgmtAddr expected
# E errorCode lastFetchAddr | C addr expected | X reset
W f 4004 deadbeef
R f 4004 deadbeef
R 3 4004 0000beef
R c 4004 dead0000
R 5 4004 00ad00ef
W f 4000 ffffffff
R f 4000 00000000
W f 0000 00000041
R f 0000 00000040
W f 0004 00000010
R f 0000 00000050
M 100 12300293
W f 0000 00000100
W f 0008 00000000
R f 4014 00000123
R f 0000 00000104
R f 0010 12300293
# Run program with ALU ops, branches and jumps
M 000 123450b7
M 004 00001117
M 008 ffb00193
M 00c 4011d213
M 010 00409313
M 014 401303b3
M 018 0011b433
M 01c 0011a4b3
M 020 00948463
M 028 00419463
M 030 0091c463
M 038 0034d463
M 040 0034e463
M 048 0091f463
M 050 00418463
M 054 0080056f
M 05c 00c505e7
M 064 00000073
W f 0000 00000000
E 1 00000064
R f 0000 00000064
R f 4004 12345000
R f 4008 00001004
R f 4010 fffffffd
R f 4018 23450000
R f 401c 1110b000
R f 4020 00000000
R f 4024 00000001
R f 4028 00000058
R f 402c 00000060
# Loads and stores, then a misaligned word load
X
M 200 015a00a3
M 204 015a1123
M 208 015a2223
M 20c 005a0b03
M 210 005a4b83
M 214 006a1c03
M 218 002a5c83
M 21c 000a2d03
M 220 002a2d83
W f 0000 00000200
W f 4050 00000300
W f 4054 8899aabb
W f 406c 5a5a5a5a
E 2 00000220
C 300 aabbbb00
C 304 8899aabb
R f 4058 ffffffaa
R f 405c 000000aa
R f 4060 ffff8899
R f 4064 0000aabb
R f 4068 aabbbb00
R f 406c 5a5a5a5a
R f 0000 00000220

//--- bench/rv32iCoreBench.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module rv32iCoreBench import coreBusPkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int MEM_WORDS = 256;

	logic clk;
	logic rst;
	mgmtCommand_t mgmt;
	logic [`XLEN-1:0] mgmtReadData;
	memRequest_t memRequest;
	logic [`XLEN-1:0] memoryDataRead;
	logic memoryBusy;
	coreState_t coreState;
	errorCode_t errorCode;

	logic [`XLEN-1:0] memory [0:MEM_WORDS-1];
	logic [31:0] lfsrState;
	logic pending;
	logic [1:0] remaining;
	logic [`XLEN-1:0] lastAddress;

	rv32iCore rv32iCore_i (
		.clk(clk),
		.rst(rst),
		.mgmt(mgmt),
		.mgmtReadData(mgmtReadData),
		.memRequest(memRequest),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.coreState(coreState),
		.errorCode(errorCode)
	);

	always #10 clk = !clk;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic failWith(input string text);
		$display("%s", text);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Memory model holds busy high until a random delay has passed
	always @(posedge clk) begin
		if (rst) begin
			memoryBusy <= 1'b1;
			pending = 1'b0;
		end else if (memRequest.readEnable || memRequest.writeEnable) begin
			lastAddress = memRequest.address;
			if (!memoryBusy) begin
				if (memRequest.writeEnable) begin
					for (int b = 0; b < 4; b++) begin
						if (memRequest.byteSelect[b])
							memory[memRequest.address[9:2]][8*b +: 8] =
								memRequest.writeData[8*b +: 8];
					end
				end
				memoryBusy <= 1'b1;
				pending = 1'b0;
			end else begin
				if (!pending) begin
					pending = 1'b1;
					lfsrState = lfsrStep(lfsrState);
					remaining[1] = lfsrState[0];
					lfsrState = lfsrStep(lfsrState);
					remaining[0] = lfsrState[0];
				end
				if (remaining == '0) begin
					memoryBusy <= 1'b0;
					memoryDataRead <= memory[memRequest.address[9:2]];
				end else
					remaining--;
			end
		end
	end

	task automatic resetCore();
		@(posedge clk);
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic waitForHalt();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (coreState != stateHalt) begin
			if (cycles == TIMEOUT_CYCLES)
				failWith("Timed out waiting for the core to return to halt");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic writeMgmt(input logic [3:0] mask, input logic [15:0] addr,
		input logic [31:0] data);
		@(posedge clk);
		mgmt.writeEnable <= 1'b1;
		mgmt.byteSelect <= mask;
		mgmt.address <= addr;
		mgmt.writeData <= data;
		@(posedge clk);
		mgmt.writeEnable <= 1'b0;
		waitForHalt();
	endtask

	task automatic checkMgmtRead(input logic [3:0] mask, input logic [15:0] addr,
		input logic [31:0] expected);
		@(posedge clk);
		mgmt.byteSelect <= mask;
		mgmt.address <= addr;
		@(negedge clk);
		assert (mgmtReadData == expected)
			else failWith($sformatf(
				"** Error at %0t ns: mgmt read 0x%h mask %b gave 0x%h, expected 0x%h",
				$time, addr, mask, mgmtReadData, expected));
	endtask

	task automatic runUntilError(input logic [3:0] expectedCode,
		input logic [31:0] expectedLast);
		int cycles;
		cycles = 0;
		@(posedge clk);
		mgmt.run <= 1'b1;
		@(negedge clk);
		while (errorCode == '0) begin
			if (cycles == TIMEOUT_CYCLES)
				failWith("Timed out waiting for the core to latch an error");
			@(negedge clk);
			cycles++;
		end
		assert (errorCode == expectedCode)
			else failWith($sformatf("** Error at %0t ns: error code %b, expected %b",
				$time, errorCode, expectedCode));
		// The last enabled access must be the fetch of the faulting word
		assert (lastAddress == expectedLast)
			else failWith($sformatf(
				"** Error at %0t ns: last memory access 0x%h, expected 0x%h",
				$time, lastAddress, expectedLast));
		@(posedge clk);
		mgmt.run <= 1'b0;
	endtask

	initial begin
		int fd;
		string line;
		byte command;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		clk = 1'b0;
		rst <= 1'b1;
		mgmt <= '0;
		memoryDataRead <= '0;
		memoryBusy <= 1'b1;
		lfsrState = 32'h4c4c_4843;
		pending = 1'b0;
		remaining = '0;
		lastAddress = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			memory[i] = '0;
		fd = $fopen("bench/programInput.txt", "r");
		if (fd == 0)
			failWith("Could not open bench/programInput.txt");
		resetCore();
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 1)
				continue;
			command = line.getc(0);
			a = '0;
			b = '0;
			c = '0;
			if (line.len() > 1)
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
			case (command)
				"M": memory[a[9:2]] = b;
				"W": writeMgmt(a[3:0], b[15:0], c);
				"R": checkMgmtRead(a[3:0], b[15:0], c);
				"E": runUntilError(a[3:0], b);
				"X": resetCore();
				"C": begin
					assert (memory[a[9:2]] == b)
						else failWith($sformatf(
							"** Error at %0t ns: memory 0x%h holds 0x%h, expected 0x%h",
							$time, a, memory[a[9:2]], b));
				end
				default: ;
			endcase
		end
		$fclose(fd);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/rvIsaPkg.sv
source/coreBusPkg.sv
source/instructionDecoder.sv
source/executeUnit.sv
source/loadStoreUnit.sv
source/registerFile.sv
source/rv32iCore.sv
bench/rv32iCoreBench.sv

//--- source/coreBusPkg.sv
`include "core_defs.svh"

package coreBusPkg;

	// Host side, level sensitive
	typedef struct packed {
		logic run;
		logic writeEnable;
		logic [3:0] byteSelect;
		logic [`MGMT_ADDR_W-1:0] address;
		logic [`XLEN-1:0] writeData;
	} mgmtCommand_t;

	// Held steady while memory is busy
	typedef struct packed {
		logic [`XLEN-1:0] address;
		logic [3:0] byteSelect;
		logic writeEnable;
		logic readEnable;
		logic [`XLEN-1:0] writeData;
	} memRequest_t;

	typedef enum logic [1:0] {
		stateHalt = 2'd0,
		stateFetch = 2'd2,
		stateExecute = 2'd3
	} coreState_t;

	typedef logic [3:0] errorCode_t;

endpackage

//--- source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath widths
`define XLEN 32
`define REG_INDEX_W 5
`define REG_COUNT 32

// Management address map, top two bits select the area
`define MGMT_ADDR_W 16
`define MGMT_SPACE_SYSTEM 2'd0
`define MGMT_SPACE_REGS 2'd1

// Offsets inside the PC block
`define MGMT_PC_SET 4'h0
`define MGMT_PC_JUMP 4'h4
`define MGMT_PC_STEP 4'h8

// Error code bit positions
`define ERR_INVALID 0
`define ERR_MISALIGNED 1

`define RESET_PC 32'h0000_0000

`endif

//--- source/executeUnit.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module executeUnit import rvIsaPkg::*; (
	input decodedInstr_t decoded,
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] rs1Value,
	input logic [`XLEN-1:0] rs2Value,
	output logic [`XLEN-1:0] aluResult,
	output logic [`XLEN-1:0] linkValue,
	output logic [`XLEN-1:0] nextPc,
	output logic [`XLEN-1:0] effectiveAddress
);

	function automatic logic [`XLEN-1:0] reverseBits(input logic [`XLEN-1:0] value);
		logic [`XLEN-1:0] reversed;
		for (int i = 0; i < `XLEN; i++) begin
			reversed[i] = value[`XLEN-1-i];
		end
		return reversed;
	endfunction

	aluOp_t aluOp;
	branchCond_t condition;
	logic [`XLEN-1:0] operandA;
	logic [`XLEN-1:0] operandB;
	logic [`XLEN-1:0] sum;
	logic [`XLEN:0] difference;
	logic equal;
	logic lessSigned;
	logic lessUnsigned;
	logic shiftLeft;
	logic [`XLEN-1:0] shiftInput;
	logic [`XLEN:0] shiftExtended;
	logic [`XLEN:0] shiftedRaw;
	logic [`XLEN-1:0] aluValue;
	logic takeBranch;
	logic [`XLEN-1:0] pcTarget;
	logic [`XLEN-1:0] jumpTarget;

	assign aluOp = aluOp_t'(decoded.funct3);
	assign condition = branchCond_t'(decoded.funct3);

	assign operandA = decoded.auipc ? programCounter : rs1Value;
	assign operandB = (decoded.auipc || decoded.aluImm) ? decoded.immediate : rs2Value;

	// Compare through a 33 bit subtraction
	assign sum = operandA + operandB;
	assign difference = {1'b0, operandA} - {1'b0, operandB};
	assign equal = difference[`XLEN-1:0] == '0;
	assign lessUnsigned = difference[`XLEN];
	assign lessSigned = (operandA[`XLEN-1] ^ operandB[`XLEN-1]) ? operandA[`XLEN-1]
		: difference[`XLEN];

	// Single right shifter, left shift by reversing around it
	assign shiftLeft = aluOp == aluSll;
	assign shiftInput = shiftLeft ? reverseBits(operandA) : operandA;
	assign shiftExtended = {decoded.alternate && shiftInput[`XLEN-1] && !shiftLeft, shiftInput};
	assign shiftedRaw = $signed(shiftExtended) >>> operandB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd: aluValue = decoded.alternate ? difference[`XLEN-1:0] : sum;
			aluSll: aluValue = reverseBits(shiftedRaw[`XLEN-1:0]);
			aluSlt: aluValue = {{(`XLEN-1){1'b0}}, lessSigned};
			aluSltu: aluValue = {{(`XLEN-1){1'b0}}, lessUnsigned};
			aluXor: aluValue = operandA ^ operandB;
			aluSr: aluValue = shiftedRaw[`XLEN-1:0];
			aluOr: aluValue = operandA | operandB;
			aluAnd: aluValue = operandA & operandB;
		endcase
	end

	always_comb begin
		case (condition)
			brEq: takeBranch = equal;
			brNe: takeBranch = !equal;
			brLt: takeBranch = lessSigned;
			brGe: takeBranch = !lessSigned;
			brLtu: takeBranch = lessUnsigned;
			brGeu: takeBranch = !lessUnsigned;
			default: takeBranch = 1'b0;
		endcase
	end

	assign aluResult = decoded.lui ? decoded.immediate : decoded.auipc ? sum : aluValue;
	assign linkValue = programCounter + `XLEN'(4);
	assign pcTarget = programCounter + decoded.immediate;
	assign effectiveAddress = rs1Value + decoded.immediate;

	assign jumpTarget = decoded.jalr ? effectiveAddress
		: (decoded.jal || (decoded.branch && takeBranch)) ? pcTarget
		: linkValue;
	assign nextPc = {jumpTarget[`XLEN-1:1], 1'b0};

endmodule

//--- source/instructionDecoder.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module instructionDecoder import rvIsaPkg::*; (
	input logic [`XLEN-1:0] instruction,
	output decodedInstr_t decoded
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;
	logic [9:0] classFlags;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	assign immI = {{21{instruction[31]}}, instruction[30:20]};
	assign immS = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign immU = {instruction[31:12], 12'h000};
	assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	// One flag per class, system opcodes fall through to invalid
	assign classFlags = {
		opcode == opLui,
		opcode == opAuipc,
		opcode == opJal,
		opcode == opJalr && funct3 == 3'b000,
		opcode == opBranch && funct3[2:1] != 2'b01,
		opcode == opLoad && funct3 != 3'b011 && funct3[2:1] != 2'b11,
		opcode == opStore && !funct3[2] && funct3[1:0] != 2'b11,
		opcode == opAluImm && (funct3 != 3'b001 || funct7 == 7'b0000000)
			&& (funct3 != 3'b101 || funct7 == 7'b0000000 || funct7 == 7'b0100000),
		opcode == opAlu && (funct7 == 7'b0000000
			|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))),
		opcode == opFence && funct3 == 3'b000
	};

	always_comb begin
		decoded = '0;
		{decoded.lui, decoded.auipc, decoded.jal, decoded.jalr, decoded.branch,
			decoded.load, decoded.store, decoded.aluImm, decoded.alu,
			decoded.fence} = classFlags;
		decoded.invalid = !$onehot(classFlags);
		decoded.rd = instruction[11:7];
		decoded.rs1 = instruction[19:15];
		decoded.rs2 = instruction[24:20];
		decoded.funct3 = funct3;
		// SUB and SRA/SRAI only, ADDI keeps bit 30 as immediate
		decoded.alternate = instruction[30]
			&& (decoded.alu || (decoded.aluImm && funct3 == 3'b101));
		if (decoded.lui || decoded.auipc)
			decoded.immediate = immU;
		else if (decoded.jal)
			decoded.immediate = immJ;
		else if (decoded.branch)
			decoded.immediate = immB;
		else if (decoded.store)
			decoded.immediate = immS;
		else
			decoded.immediate = immI;
		case (funct3[1:0])
			2'b00: decoded.memSize = memByte;
			2'b01: decoded.memSize = memHalf;
			default: decoded.memSize = memWord;
		endcase
		decoded.loadSigned = !funct3[2];
	end

	always_comb begin
		assert ($onehot0(classFlags))
			else $error("decoder raised more than one instruction class");
	end

endmodule

//--- source/loadStoreUnit.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module loadStoreUnit import rvIsaPkg::*, coreBusPkg::*; (
	input decodedInstr_t decoded,
	input logic fetching,
	input logic executing,
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] effectiveAddress,
	input logic [`XLEN-1:0] rs2Value,
	input logic [`XLEN-1:0] memoryDataRead,
	input logic memoryBusy,
	output memRequest_t memRequest,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned,
	output logic done
);

	logic dataAccess;
	logic [`XLEN-1:0] targetAddress;
	logic [1:0] laneIndex;
	logic [4:0] laneShift;
	logic [3:0] baseMask;
	logic [6:0] wideMask;
	logic [`XLEN-1:0] alignedRead;

	assign dataAccess = executing && !decoded.invalid && (decoded.load || decoded.store);
	assign targetAddress = fetching ? programCounter : effectiveAddress;
	// Fetch always reads the whole word
	assign laneIndex = fetching ? 2'b00 : effectiveAddress[1:0];
	assign laneShift = {laneIndex, 3'b000};

	always_comb begin
		if (fetching)
			baseMask = 4'b1111;
		else begin
			case (decoded.memSize)
				memByte: baseMask = 4'b0001;
				memHalf: baseMask = 4'b0011;
				default: baseMask = 4'b1111;
			endcase
		end
	end

	// Lanes spilling past byte 3 mean the access crosses the word
	assign wideMask = {3'b000, baseMask} << laneIndex;
	assign misaligned = dataAccess && wideMask[6:4] != 3'b000;

	always_comb begin
		memRequest = '0;
		memRequest.readEnable = fetching || (dataAccess && decoded.load && !misaligned);
		memRequest.writeEnable = dataAccess && decoded.store && !misaligned;
		if (memRequest.readEnable || memRequest.writeEnable) begin
			memRequest.address = {targetAddress[`XLEN-1:2], 2'b00};
			memRequest.byteSelect = wideMask[3:0];
		end
		if (memRequest.writeEnable)
			memRequest.writeData = rs2Value << laneShift;
	end

	assign alignedRead = memoryDataRead >> laneShift;

	always_comb begin
		case (decoded.memSize)
			memByte: loadData = {{24{decoded.loadSigned && alignedRead[7]}}, alignedRead[7:0]};
			memHalf: loadData = {{16{decoded.loadSigned && alignedRead[15]}}, alignedRead[15:0]};
			default: loadData = alignedRead;
		endcase
	end

	assign done = (memRequest.readEnable || memRequest.writeEnable) && !memoryBusy;

	// Fetch and execute phases come from the core FSM
	always_comb begin
		assert (!(memRequest.readEnable && memRequest.writeEnable))
			else $error("read and write enables raised together");
	end

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module registerFile (
	input logic clk,
	input logic rst,
	input logic [`REG_INDEX_W-1:0] rs1Index,
	input logic [`REG_INDEX_W-1:0] rs2Index,
	input logic [`REG_INDEX_W-1:0] mgmtIndex,
	input logic writeEnable,
	input logic [`REG_INDEX_W-1:0] writeIndex,
	input logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] rs1Value,
	output logic [`XLEN-1:0] rs2Value,
	output logic [`XLEN-1:0] mgmtValue
);

	// x0 has no storage
	logic [`XLEN-1:0] registers [1:`REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (!rst && writeEnable && writeIndex != '0) begin
			registers[writeIndex] <= writeData;
		end
	end

	assign rs1Value = (rs1Index == '0) ? '0 : registers[rs1Index];
	assign rs2Value = (rs2Index == '0) ? '0 : registers[rs2Index];
	assign mgmtValue = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];

endmodule

//--- source/rv32iCore.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module rv32iCore import rvIsaPkg::*, coreBusPkg::*; (
	input logic clk,
	input logic rst,
	input mgmtCommand_t mgmt,
	output logic [`XLEN-1:0] mgmtReadData,
	output memRequest_t memRequest,
	input logic [`XLEN-1:0] memoryDataRead,
	input logic memoryBusy,
	output coreState_t coreState,
	output errorCode_t errorCode
);

	coreState_t state;
	logic [`XLEN-1:0] programCounter;
	logic [`XLEN-1:0] instructionRegister;
	decodedInstr_t decoded;
	logic [`XLEN-1:0] rs1Value;
	logic [`XLEN-1:0] rs2Value;
	logic [`XLEN-1:0] mgmtRegValue;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] linkValue;
	logic [`XLEN-1:0] nextPc;
	logic [`XLEN-1:0] effectiveAddress;
	logic [`XLEN-1:0] loadData;
	logic misaligned;
	logic lsuDone;
	logic running;
	logic fetching;
	logic executing;
	logic [1:0] mgmtSpace;
	logic selectPc;
	logic selectInstr;
	logic selectReg;
	logic mgmtWrite;
	logic pcSet;
	logic pcJump;
	logic pcStep;
	logic regWrite;
	logic allowInstruction;
	logic [`REG_INDEX_W-1:0] mgmtIndex;
	logic [`XLEN-1:0] mgmtJumpTarget;
	logic [`XLEN-1:0] mgmtValue;
	logic fault;
	logic progress;
	logic coreWrite;
	logic [`XLEN-1:0] writeBack;
	errorCode_t newError;
	logic rfWriteEnable;
	logic [`REG_INDEX_W-1:0] rfWriteIndex;
	logic [`XLEN-1:0] rfWriteData;

	// Any latched error freezes the core until reset
	assign running = errorCode == '0;
	assign fetching = running && state == stateFetch;
	assign executing = running && state == stateExecute;
	assign coreState = state;

	// Management address decode
	assign mgmtSpace = mgmt.address[`MGMT_ADDR_W-1 -: 2];
	assign selectPc = mgmtSpace == `MGMT_SPACE_SYSTEM && mgmt.address[`MGMT_ADDR_W-3:4] == '0;
	assign selectInstr = mgmtSpace == `MGMT_SPACE_SYSTEM
		&& mgmt.address[`MGMT_ADDR_W-3:4] == (`MGMT_ADDR_W-6)'(1);
	assign selectReg = mgmtSpace == `MGMT_SPACE_REGS
		&& mgmt.address[`MGMT_ADDR_W-3:`REG_INDEX_W+2] == '0;
	assign mgmtIndex = mgmt.address[`REG_INDEX_W+1:2];

	assign mgmtWrite = !mgmt.run && mgmt.writeEnable && running && state == stateHalt;
	assign pcSet = mgmtWrite && selectPc && mgmt.address[3:0] == `MGMT_PC_SET;
	assign pcJump = mgmtWrite && selectPc && mgmt.address[3:0] == `MGMT_PC_JUMP;
	assign pcStep = mgmtWrite && selectPc && mgmt.address[3:0] == `MGMT_PC_STEP;
	assign regWrite = mgmtWrite && selectReg;
	assign allowInstruction = mgmt.run || pcStep;
	assign mgmtJumpTarget = programCounter + mgmt.writeData;

	always_comb begin
		if (mgmt.run)
			mgmtValue = '0;
		else if (selectPc)
			mgmtValue = programCounter;
		else if (selectInstr)
			mgmtValue = instructionRegister;
		else if (selectReg)
			mgmtValue = mgmtRegValue;
		else
			mgmtValue = '0;
	end

	always_comb begin
		for (int b = 0; b < 4; b++) begin
			mgmtReadData[8*b +: 8] = mgmt.byteSelect[b] ? mgmtValue[8*b +: 8] : 8'h00;
		end
	end

	instructionDecoder instructionDecoder_i (
		.instruction(instructionRegister),
		.decoded(decoded)
	);

	executeUnit executeUnit_i (
		.decoded(decoded),
		.programCounter(programCounter),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.aluResult(aluResult),
		.linkValue(linkValue),
		.nextPc(nextPc),
		.effectiveAddress(effectiveAddress)
	);

	loadStoreUnit loadStoreUnit_i (
		.decoded(decoded),
		.fetching(fetching),
		.executing(executing),
		.programCounter(programCounter),
		.effectiveAddress(effectiveAddress),
		.rs2Value(rs2Value),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.memRequest(memRequest),
		.loadData(loadData),
		.misaligned(misaligned),
		.done(lsuDone)
	);

	// Write-back
	assign fault = executing && (decoded.invalid || misaligned);
	assign progress = (decoded.load || decoded.store) ? lsuDone : 1'b1;
	assign coreWrite = executing && !fault && progress && (decoded.lui || decoded.auipc
		|| decoded.jal || decoded.jalr || decoded.alu || decoded.aluImm || decoded.load);
	assign writeBack = decoded.load ? loadData
		: (decoded.jal || decoded.jalr) ? linkValue
		: aluResult;

	assign rfWriteEnable = regWrite || coreWrite;
	assign rfWriteIndex = regWrite ? mgmtIndex : decoded.rd;
	assign rfWriteData = regWrite ? mgmt.writeData : writeBack;

	registerFile registerFile_i (
		.clk(clk),
		.rst(rst),
		.rs1Index(decoded.rs1),
		.rs2Index(decoded.rs2),
		.mgmtIndex(mgmtIndex),
		.writeEnable(rfWriteEnable),
		.writeIndex(rfWriteIndex),
		.writeData(rfWriteData),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.mgmtValue(mgmtRegValue)
	);

	always_comb begin
		newError = '0;
		newError[`ERR_INVALID] = decoded.invalid;
		newError[`ERR_MISALIGNED] = misaligned;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
			programCounter <= `RESET_PC;
			errorCode <= '0;
		end else if (running) begin
			case (state)
				stateHalt: begin
					if (allowInstruction)
						state <= stateFetch;
					else if (pcSet)
						programCounter <= {mgmt.writeData[`XLEN-1:1], 1'b0};
					else if (pcJump)
						programCounter <= {mgmtJumpTarget[`XLEN-1:1], 1'b0};
				end
				stateFetch: begin
					if (lsuDone)
						state <= stateExecute;
				end
				stateExecute: begin
					if (fault)
						errorCode <= newError;
					else if (progress) begin
						programCounter <= nextPc;
						state <= mgmt.run ? stateFetch : stateHalt;
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetching && lsuDone) begin
			instructionRegister <= memoryDataRead;
		end
	end

	// Holds across set, jump and every execute path
	assert property (@(posedge clk) disable iff (rst) !programCounter[0])
		else $error("PC bit 0 set");

endmodule

//--- source/rvIsaPkg.sv
`include "core_defs.svh"

package rvIsaPkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opAluImm = 7'b0010011,
		opAlu = 7'b0110011,
		opFence = 7'b0001111,
		opSystem = 7'b1110011
	} opcode_t;

	// Indexed by funct3
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSll = 3'b001,
		aluSlt = 3'b010,
		aluSltu = 3'b011,
		aluXor = 3'b100,
		aluSr = 3'b101,
		aluOr = 3'b110,
		aluAnd = 3'b111
	} aluOp_t;

	typedef enum logic [2:0] {
		brEq = 3'b000,
		brNe = 3'b001,
		brLt = 3'b100,
		brGe = 3'b101,
		brLtu = 3'b110,
		brGeu = 3'b111
	} branchCond_t;

	typedef enum logic [1:0] {
		memByte = 2'd0,
		memHalf = 2'd1,
		memWord = 2'd2
	} memSize_t;

	typedef struct packed {
		logic lui;
		logic auipc;
		logic jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic aluImm;
		logic alu;
		logic fence;
		logic invalid;
		logic [`REG_INDEX_W-1:0] rd;
		logic [`REG_INDEX_W-1:0] rs1;
		logic [`REG_INDEX_W-1:0] rs2;
		logic [2:0] funct3;
		logic alternate;
		logic [`XLEN-1:0] immediate;
		memSize_t memSize;
		logic loadSigned;
	} decodedInstr_t;

endpackage
